// ==== branch_alu.sv ====
`timescale 1ns/1ps
`include "branch_settings.svh"

module branch_alu (
    input  pipeline_types::bus32_t       pc,
    input  pipeline_types::bus32_t       inst,
    input  pipeline_types::alu_op_t      aluop,

    input  pipeline_types::bus32_t       reg1,
    input  pipeline_types::bus32_t       reg2,

    input  logic                         pre_is_branch_taken,
    input  pipeline_types::bus32_t       pre_branch_addr,

    output pipeline_types::branch_update update_info,
    output logic                         branch_flush,
    output pipeline_types::bus32_t       branch_alu_res
);

    // comparison.
    logic [`DATA_W:0] diff;
    logic             reg_eq;
    logic             lt_unsigned;
    logic             lt_signed;
    logic             signed_cmp;
    logic             reg_lt;

    // offsets and addresses.
    pipeline_types::bus32_t off16;
    pipeline_types::bus32_t off26;
    pipeline_types::bus32_t pc_plus_4;
    pipeline_types::bus32_t pc_plus_off16;

    logic                   is_branch;
    logic                   is_taken;
    pipeline_types::bus32_t target;
    pipeline_types::bus32_t actual_addr;

    assign reg_eq = (reg1 == reg2);

    // one subtractor, extra bit gives the unsigned borrow.
    assign diff        = {1'b0, reg1} - {1'b0, reg2};
    assign lt_unsigned = diff[`DATA_W];
    // differing signs decide directly, otherwise no overflow is possible.
    assign lt_signed   = (reg1[`DATA_W-1] != reg2[`DATA_W-1]) ? reg1[`DATA_W-1]
                                                              : diff[`DATA_W-1];

    assign signed_cmp = (aluop == `ALU_BLT) || (aluop == `ALU_BGE);
    assign reg_lt     = signed_cmp ? lt_signed : lt_unsigned;

    assign off16 = {{(`DATA_W-18){inst[25]}}, inst[25:10], 2'b00};
    assign off26 = {{(`DATA_W-28){inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    assign pc_plus_4     = pc + `DATA_W'(4);
    assign pc_plus_off16 = pc + off16;

    always_comb begin : decode
        is_branch      = 1'b1;
        is_taken       = 1'b0;
        target         = pc_plus_off16;
        branch_alu_res = '0;
        case (aluop)
            `ALU_BEQ: begin
                is_taken = reg_eq;
            end
            `ALU_BNE: begin
                is_taken = !reg_eq;
            end
            `ALU_BLT, `ALU_BLTU: begin
                is_taken = reg_lt;
            end
            `ALU_BGE, `ALU_BGEU: begin
                is_taken = !reg_lt;
            end
            `ALU_B: begin
                is_taken = 1'b1;
                target   = pc + off26;
            end
            `ALU_BL: begin
                is_taken       = 1'b1;
                target         = pc + off26;
                branch_alu_res = pc_plus_4;   // link.
            end
            `ALU_JIRL: begin
                is_taken       = 1'b1;
                target         = reg1 + off16;
                branch_alu_res = pc_plus_4;
            end
            default: begin
                is_branch = 1'b0;           // not ours.
            end
        endcase
    end

    // falls through to pc+4 when not taken.
    assign actual_addr = is_taken ? target : pc_plus_4;

    always_comb begin : resolve
        update_info.update_en           = is_branch;
        update_info.taken_or_not_actual = is_branch && is_taken;
        update_info.branch_actual_addr  = actual_addr;
        update_info.pc_dispatch         = pc;
        update_info.branch_flush        = 1'b0;
        if (is_branch) begin
            if (is_taken != pre_is_branch_taken) begin
                update_info.branch_flush = 1'b1;   // wrong direction.
            end else if (is_taken && (pre_branch_addr != target)) begin
                update_info.branch_flush = 1'b1;   // right direction, wrong target.
            end
        end
    end

    assign branch_flush = update_info.branch_flush;

endmodule

// ==== branch_exec_stage.sv ====
`timescale 1ns/1ps
`include "branch_settings.svh"

module branch_exec_stage (
    input  logic                         clk,
    input  logic                         arst_n,
    input  pipeline_types::dispatch_op_t dispatch,
    output pipeline_types::branch_update update_info,
    output pipeline_types::redirect_t    redirect,
    output pipeline_types::writeback_t   writeback
);

    logic                         ex_valid;
    pipeline_types::dispatch_op_t ex_op;

    pipeline_types::branch_update alu_update;
    logic                         alu_flush;
    pipeline_types::bus32_t       alu_res;
    logic                         flush_now;
    logic                         is_link;

    logic                         rd_valid;
    logic                         rd_flush;
    pipeline_types::bus32_t       rd_target;
    logic                         wb_valid;
    pipeline_types::bus32_t       wb_data;

    // op register, a resolving flush kills the op arriving on this edge.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dispatch.valid && !flush_now;
        end
    end

    always_ff @(posedge clk) begin
        ex_op <= dispatch;
    end

    branch_alu i_branch_alu (
        .pc                  (ex_op.pc),
        .inst                (ex_op.inst),
        .aluop               (ex_op.aluop),
        .reg1                (ex_op.reg1),
        .reg2                (ex_op.reg2),
        .pre_is_branch_taken (ex_op.pre_is_branch_taken),
        .pre_branch_addr     (ex_op.pre_branch_addr),
        .update_info         (alu_update),
        .branch_flush        (alu_flush),
        .branch_alu_res      (alu_res)
    );

    assign flush_now = ex_valid && alu_flush;
    assign is_link   = (ex_op.aluop == `ALU_BL) || (ex_op.aluop == `ALU_JIRL);

    always_comb begin
        update_info              = alu_update;
        update_info.update_en    = ex_valid && alu_update.update_en;
        update_info.branch_flush = flush_now;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= 1'b0;
            rd_flush <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            rd_valid <= update_info.update_en;
            rd_flush <= flush_now;
            wb_valid <= ex_valid && is_link;
        end
    end

    always_ff @(posedge clk) begin
        rd_target <= update_info.branch_actual_addr;
        wb_data   <= alu_res;
    end

    assign redirect.valid  = rd_valid;
    assign redirect.flush  = rd_flush;
    assign redirect.target = rd_target;
    assign writeback.valid = wb_valid;
    assign writeback.data  = wb_data;

endmodule

// ==== branch_predictor.sv ====
`timescale 1ns/1ps
`include "branch_settings.svh"

module branch_predictor (
    input  logic                         clk,
    input  logic                         arst_n,
    input  pipeline_types::bus32_t       fetch_pc,
    output pipeline_types::prediction_t  prediction,
    input  pipeline_types::branch_update update_info
);

    logic [`BHT_DEPTH-1:0]    entry_valid;
    pipeline_types::counter_t counter_tab [`BHT_DEPTH];
    pipeline_types::bus32_t   target_tab  [`BHT_DEPTH];

    pipeline_types::bht_index_t rd_idx;
    pipeline_types::bht_index_t wr_idx;
    pipeline_types::counter_t   rd_cnt;
    pipeline_types::counter_t   wr_cnt;
    pipeline_types::counter_t   next_cnt;
    logic                       wr_hit;

    // word aligned pc, drop the low two bits.
    assign rd_idx = fetch_pc[`BHT_INDEX_W+1:2];
    assign wr_idx = update_info.pc_dispatch[`BHT_INDEX_W+1:2];

    assign rd_cnt = counter_tab[rd_idx];

    // weakly taken or above.
    assign prediction.taken  = entry_valid[rd_idx] && rd_cnt[1];
    assign prediction.target = target_tab[rd_idx];

    assign wr_cnt = counter_tab[wr_idx];
    assign wr_hit = entry_valid[wr_idx];

    always_comb begin
        next_cnt = wr_cnt;
        if (update_info.taken_or_not_actual) begin
            if (!wr_hit) begin
                next_cnt = 2'd2;            // fresh entry, 1 then one step up.
            end else if (wr_cnt != 2'd3) begin
                next_cnt = wr_cnt + 2'd1;
            end
        end else if (wr_cnt != 2'd0) begin
            next_cnt = wr_cnt - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entry_valid <= '0;
        end else if (update_info.update_en && update_info.taken_or_not_actual) begin
            entry_valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update_info.update_en) begin
            if (update_info.taken_or_not_actual) begin
                counter_tab[wr_idx] <= next_cnt;
                target_tab[wr_idx]  <= update_info.branch_actual_addr;
            end else if (wr_hit) begin
                counter_tab[wr_idx] <= next_cnt;   // only trained entries decay.
            end
        end
    end

endmodule

// ==== branch_settings.svh ====
`ifndef BRANCH_SETTINGS_SVH
`define BRANCH_SETTINGS_SVH

// data path and address width.
`define DATA_W      32
`define ALU_OP_W    8

// predictor table geometry.
`define BHT_INDEX_W 6
`define BHT_DEPTH   (1 << `BHT_INDEX_W)

// branch unit operation codes.
`define ALU_BEQ     8'h50
`define ALU_BNE     8'h51
`define ALU_BLT     8'h52
`define ALU_BGE     8'h53
`define ALU_BLTU    8'h54
`define ALU_BGEU    8'h55
`define ALU_B       8'h56
`define ALU_BL      8'h57
`define ALU_JIRL    8'h58

// plain arithmetic op, not handled here.
`define ALU_ADD     8'h01

`endif

// ==== branch_unit.f ====
+incdir+.
pipeline_types.sv
branch_alu.sv
branch_exec_stage.sv
branch_predictor.sv
branch_unit_top.sv
tb_branch_unit.sv

// ==== branch_unit_top.sv ====
`timescale 1ns/1ps

module branch_unit_top (
    input  logic                         clk,
    input  logic                         arst_n,
    input  pipeline_types::dispatch_op_t dispatch,
    input  pipeline_types::bus32_t       fetch_pc,
    output pipeline_types::prediction_t  prediction,
    output pipeline_types::redirect_t    redirect,
    output pipeline_types::writeback_t   writeback
);

    // resolved branch feeding back into the table.
    pipeline_types::branch_update update_info;

    branch_exec_stage i_branch_exec_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .dispatch    (dispatch),
        .update_info (update_info),
        .redirect    (redirect),
        .writeback   (writeback)
    );

    branch_predictor i_branch_predictor (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_pc    (fetch_pc),
        .prediction  (prediction),
        .update_info (update_info)
    );

endmodule

// ==== pipeline_types.sv ====
`include "branch_settings.svh"

package pipeline_types;

    typedef logic [`DATA_W-1:0]      bus32_t;
    typedef logic [`ALU_OP_W-1:0]    alu_op_t;
    typedef logic [`BHT_INDEX_W-1:0] bht_index_t;
    typedef logic [1:0]              counter_t;   // 2-bit saturating.

    // one op as issued by dispatch, prediction rides along.
    typedef struct packed {
        logic    valid;
        bus32_t  pc;
        bus32_t  inst;
        alu_op_t aluop;
        bus32_t  reg1;
        bus32_t  reg2;
        logic    pre_is_branch_taken;
        bus32_t  pre_branch_addr;
    } dispatch_op_t;

    typedef struct packed {
        logic   update_en;
        logic   taken_or_not_actual;
        logic   branch_flush;
        bus32_t branch_actual_addr;
        bus32_t pc_dispatch;
    } branch_update;

    typedef struct packed {
        logic   valid;
        logic   flush;
        bus32_t target;
    } redirect_t;

    typedef struct packed {
        logic   valid;
        bus32_t data;
    } writeback_t;

    typedef struct packed {
        logic   taken;
        bus32_t target;
    } prediction_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build the branch unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_branch_unit -f branch_unit.f -o tb_branch_unit \
    && ./obj_dir/tb_branch_unit | tee /dev/stderr | grep -q "Simulation passed" \
    && echo "run_sim: ok" \
    || { echo "run_sim: failed"; exit 1; }

exit 0

// ==== tb_branch_unit.sv ====
`timescale 1ns/1ps
`include "branch_settings.svh"

module tb_branch_unit;

    // what the model predicts for one resolved op.
    typedef struct packed {
        logic                   is_br;
        logic                   taken;
        logic                   flush;
        logic                   link;
        pipeline_types::bus32_t target;
        pipeline_types::bus32_t actual;
        pipeline_types::bus32_t redir;
    } expect_t;

    localparam pipeline_types::bus32_t LEARN_PC = 32'h0000_40f0;
    localparam int                     WAIT_MAX = 8;

    logic                         clk = 1'b0;
    logic                         arst_n;
    pipeline_types::dispatch_op_t dispatch;
    pipeline_types::bus32_t       fetch_pc;
    pipeline_types::prediction_t  prediction;
    pipeline_types::redirect_t    redirect;
    pipeline_types::writeback_t   writeback;

    // reference copy of the predictor table.
    logic                     m_valid  [`BHT_DEPTH];
    pipeline_types::counter_t m_cnt    [`BHT_DEPTH];
    pipeline_types::bus32_t   m_target [`BHT_DEPTH];

    int unsigned seed_res;
    int          checks = 0;
    int          errors = 0;

    branch_unit_top i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .dispatch   (dispatch),
        .fetch_pc   (fetch_pc),
        .prediction (prediction),
        .redirect   (redirect),
        .writeback  (writeback)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input pipeline_types::bus32_t actual,
                               input pipeline_types::bus32_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    function automatic pipeline_types::bus32_t enc16(input logic [15:0] off);
        return {6'b0, off, 10'b0};
    endfunction

    // low half of the offset goes to [25:10].
    function automatic pipeline_types::bus32_t enc26(input logic [25:0] off);
        return {6'b0, off[15:0], off[25:16]};
    endfunction

    function automatic pipeline_types::dispatch_op_t make_op(
        input pipeline_types::alu_op_t aluop, input pipeline_types::bus32_t pc,
        input pipeline_types::bus32_t inst, input pipeline_types::bus32_t reg1,
        input pipeline_types::bus32_t reg2, input logic pre_taken,
        input pipeline_types::bus32_t pre_addr);
        pipeline_types::dispatch_op_t op;
        op.valid               = 1'b1;
        op.pc                  = pc;
        op.inst                = inst;
        op.aluop               = aluop;
        op.reg1                = reg1;
        op.reg2                = reg2;
        op.pre_is_branch_taken = pre_taken;
        op.pre_branch_addr     = pre_addr;
        return op;
    endfunction

    function automatic expect_t model_resolve(input pipeline_types::dispatch_op_t op);
        expect_t                e;
        logic signed [15:0]     o16;
        logic signed [25:0]     o26;
        logic signed [31:0]     off16;
        logic signed [31:0]     off26;
        pipeline_types::bus32_t pc4;
        o16      = op.inst[25:10];
        o26      = {op.inst[9:0], op.inst[25:10]};
        off16    = 32'(o16) * 4;
        off26    = 32'(o26) * 4;
        pc4      = op.pc + 32'd4;
        e        = '0;
        e.is_br  = 1'b1;
        e.target = op.pc + off16;
        case (op.aluop)
            `ALU_BEQ:  e.taken = (op.reg1 == op.reg2);
            `ALU_BNE:  e.taken = (op.reg1 != op.reg2);
            `ALU_BLT:  e.taken = ($signed(op.reg1) < $signed(op.reg2));
            `ALU_BGE:  e.taken = ($signed(op.reg1) >= $signed(op.reg2));
            `ALU_BLTU: e.taken = (op.reg1 < op.reg2);
            `ALU_BGEU: e.taken = (op.reg1 >= op.reg2);
            `ALU_B: begin
                e.taken  = 1'b1;
                e.target = op.pc + off26;
            end
            `ALU_BL: begin
                e.taken  = 1'b1;
                e.link   = 1'b1;
                e.target = op.pc + off26;
            end
            `ALU_JIRL: begin
                e.taken  = 1'b1;
                e.link   = 1'b1;
                e.target = op.reg1 + off16;
            end
            default: e.is_br = 1'b0;
        endcase
        e.actual = e.taken ? e.target : pc4;
        e.flush  = e.is_br && ((e.taken != op.pre_is_branch_taken) ||
                               (e.taken && (op.pre_branch_addr != e.target)));
        e.redir  = (op.pre_is_branch_taken && !e.taken) ? pc4 : e.actual;
        return e;
    endfunction

    task automatic model_update(input pipeline_types::bus32_t pc, input logic taken,
                                input pipeline_types::bus32_t target);
        pipeline_types::bht_index_t idx;
        idx = pc[`BHT_INDEX_W+1:2];
        if (taken) begin
            if (!m_valid[idx]) begin
                m_cnt[idx] = 2'd1;          // new entry.
            end
            m_valid[idx]  = 1'b1;
            m_target[idx] = target;
            if (m_cnt[idx] != 2'd3) begin
                m_cnt[idx] = m_cnt[idx] + 2'd1;
            end
        end else if (m_valid[idx] && (m_cnt[idx] != 2'd0)) begin
            m_cnt[idx] = m_cnt[idx] - 2'd1;
        end
    endtask

    task automatic wait_redirect(output logic seen, output int cycles);
        seen   = 1'b0;
        cycles = 0;
        while ((cycles < WAIT_MAX) && !seen) begin
            @(negedge clk);
            cycles++;
            seen = redirect.valid;
        end
        if (!seen) begin
            errors++;
            $display("timeout: no redirect from the branch unit within %0d cycles", WAIT_MAX);
        end
    endtask

    task automatic check_resolved(input pipeline_types::dispatch_op_t op, input expect_t e);
        check_value("redirect.valid", 32'(redirect.valid), 32'(1'b1));
        check_value("redirect.flush", 32'(redirect.flush), 32'(e.flush));
        check_value("redirect.target", redirect.target, e.redir);
        check_value("writeback.valid", 32'(writeback.valid), 32'(e.link));
        if (e.link) begin
            check_value("writeback.data", writeback.data, op.pc + 32'd4);
        end
        model_update(op.pc, e.taken, e.actual);
    endtask

    task automatic run_op(input pipeline_types::dispatch_op_t op);
        expect_t e;
        logic    seen;
        int      cycles;
        e = model_resolve(op);
        @(posedge clk);
        dispatch <= op;
        @(posedge clk);
        dispatch.valid <= 1'b0;
        if (e.is_br) begin
            wait_redirect(seen, cycles);
            if (seen) begin
                check_value("redirect latency", 32'(cycles), 32'd2);   // two edges after sampling.
                check_resolved(op, e);
            end
        end else begin
            repeat (3) begin            // nothing may come out.
                @(negedge clk);
                check_value("redirect.valid", 32'(redirect.valid), 32'(1'b0));
                check_value("writeback.valid", 32'(writeback.valid), 32'(1'b0));
            end
        end
    endtask

    task automatic check_lookup(input pipeline_types::bus32_t pc);
        pipeline_types::bht_index_t idx;
        idx = pc[`BHT_INDEX_W+1:2];
        @(posedge clk);
        fetch_pc <= pc;
        @(negedge clk);
        check_value("prediction.taken", 32'(prediction.taken),
                    32'(m_valid[idx] && (m_cnt[idx] >= 2'd2)));
        if (m_valid[idx]) begin
            check_value("prediction.target", prediction.target, m_target[idx]);
        end
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_value("redirect.valid", 32'(redirect.valid), 32'(1'b0));
        check_value("redirect.flush", 32'(redirect.flush), 32'(1'b0));
        check_value("writeback.valid", 32'(writeback.valid), 32'(1'b0));
        check_lookup(32'h0000_0000);
    endtask

    task automatic test_conditional();
        pipeline_types::alu_op_t cond_ops [6];
        pipeline_types::bus32_t  a_vals   [5];
        pipeline_types::bus32_t  b_vals   [5];
        pipeline_types::bus32_t  pc;
        int                      i;
        int                      k;
        cond_ops = '{`ALU_BEQ, `ALU_BNE, `ALU_BLT, `ALU_BGE, `ALU_BLTU, `ALU_BGEU};
        for (i = 0; i < 6; i++) begin
            a_vals = '{$urandom(), 32'h1234_5678, 32'h8000_0000, 32'h0000_0001, 32'hffff_ffff};
            b_vals = '{$urandom(), 32'h1234_5678, 32'h0000_0001, 32'h8000_0000, 32'h0000_0000};
            for (k = 0; k < 5; k++) begin
                pc = 32'h0001_0000 + (i * 5 + k) * 4;
                run_op(make_op(cond_ops[i], pc, enc16(16'($urandom())), a_vals[k], b_vals[k],
                               1'b0, 32'h0));
            end
        end
    endtask

    task automatic test_jumps();
        pipeline_types::bus32_t pc;
        int                     n;
        for (n = 0; n < 4; n++) begin
            pc = 32'h0002_0000 + n * 16;
            run_op(make_op(`ALU_B, pc, enc26(26'($urandom())), $urandom(), $urandom(),
                           1'b0, 32'h0));
            run_op(make_op(`ALU_BL, pc + 32'd4, enc26(26'($urandom())), $urandom(),
                           $urandom(), 1'b0, 32'h0));
            run_op(make_op(`ALU_JIRL, pc + 32'd8, enc16(16'($urandom())), $urandom(),
                           $urandom(), 1'b0, 32'h0));
        end
    endtask

    task automatic test_prediction();
        pipeline_types::dispatch_op_t op;
        expect_t                      e;
        op = make_op(`ALU_BEQ, 32'h0000_5000, enc16(16'h0020), 32'h9, 32'h9, 1'b1, 32'h0);
        e  = model_resolve(op);
        op.pre_branch_addr = e.target;      // right guess.
        run_op(op);
        op.pre_branch_addr = e.target + 32'd8;
        run_op(op);
        op = make_op(`ALU_BNE, 32'h0000_5010, enc16(16'h0020), 32'h9, 32'h9, 1'b1,
                     32'h0000_5090);
        run_op(op);
    endtask

    task automatic test_squash();
        pipeline_types::dispatch_op_t first;
        pipeline_types::dispatch_op_t bl;
        expect_t                      e1;
        expect_t                      e2;
        logic                         seen;
        int                           cycles;
        int                           pass_no;
        for (pass_no = 0; pass_no < 2; pass_no++) begin
            // only the first pass flushes.
            first = make_op(`ALU_BEQ, 32'h0000_3000 + pass_no * 256, enc16(16'h0040),
                            32'h55, (pass_no == 0) ? 32'h55 : 32'h66, 1'b0, 32'h0);
            bl    = make_op(`ALU_BL, first.pc + 32'd4, enc26(26'h000_0100), 32'h0, 32'h0,
                            1'b0, 32'h0);
            e1 = model_resolve(first);
            e2 = model_resolve(bl);
            @(posedge clk);
            dispatch <= first;
            @(posedge clk);
            dispatch <= bl;
            @(posedge clk);
            dispatch.valid <= 1'b0;
            wait_redirect(seen, cycles);
            if (seen) begin
                check_value("redirect latency", 32'(cycles), 32'd1);
                check_resolved(first, e1);
                @(negedge clk);
                if (pass_no == 0) begin
                    check_value("redirect.valid", 32'(redirect.valid), 32'(1'b0));
                    check_value("writeback.valid", 32'(writeback.valid), 32'(1'b0));
                end else begin
                    check_resolved(bl, e2);
                end
            end
        end
    endtask

    task automatic test_learning();
        int n;
        for (n = 0; n < 2; n++) begin
            run_op(make_op(`ALU_BEQ, LEARN_PC, enc16(16'h0100), 32'h7, 32'h7, 1'b0, 32'h0));
            check_lookup(LEARN_PC);
        end
        for (n = 0; n < 2; n++) begin
            run_op(make_op(`ALU_BEQ, LEARN_PC, enc16(16'h0100), 32'h7, 32'h8, 1'b0, 32'h0));
            check_lookup(LEARN_PC);
        end
    endtask

    task automatic test_non_branch();
        run_op(make_op(`ALU_ADD, LEARN_PC, 32'h0, $urandom(), $urandom(), 1'b1, 32'h0));
        check_lookup(LEARN_PC);             // table untouched.
    endtask

    initial begin
        int i;
        seed_res = $urandom(20209);
        arst_n   = 1'b0;
        dispatch = '0;
        fetch_pc = '0;
        for (i = 0; i < `BHT_DEPTH; i++) begin
            m_valid[i]  = 1'b0;
            m_cnt[i]    = 2'd0;
            m_target[i] = '0;
        end
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        test_reset_state();
        test_conditional();
        test_jumps();
        test_prediction();
        test_squash();
        test_learning();
        test_non_branch();
        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
